//--- logic/thin_pkg.sv
`default_nettype none

package thin_pkg;

   // Image geometry
   localparam int ROW_WIDTH = 32;
   localparam int ROW_COUNT = 32;

   // Feeder stays busy until the last row has left the pipeline
   localparam int SCAN_LAST = ROW_COUNT + 1;

   // Bit 31 is the leftmost pixel
   typedef logic [ROW_WIDTH-1:0] row_t;
   typedef logic [$clog2(ROW_COUNT)-1:0] row_index_t;
   typedef logic [$clog2(SCAN_LAST+1)-1:0] scan_count_t;

   // West, centre, east from bit 2 down to bit 0
   typedef logic [2:0] cell_slice_t;

endpackage

`default_nettype wire

//--- logic/bus_pkg.sv
`default_nettype none

package bus_pkg;

   typedef logic [31:0] wb_data_t;
   typedef logic [6:0]  wb_addr_t;

   // Register map, word addresses
   localparam wb_addr_t IN_BASE     = 7'h00;
   localparam wb_addr_t OUT_BASE    = 7'h20;
   localparam wb_addr_t CTRL_ADDR   = 7'h40;
   localparam wb_addr_t STATUS_ADDR = 7'h41;

   // Upper address bits that select a 32-row region
   localparam wb_addr_t ROW_REGION_MASK = 7'h60;

endpackage

`default_nettype wire

//--- logic/row_if.sv
`timescale 1ns/1ps
`default_nettype none

interface row_if import thin_pkg::*; ();

   logic       valid;
   row_index_t index;
   row_t       top;
   row_t       center;
   row_t       bottom;

   modport source (
      output valid, index, top, center, bottom
   );

   // One item per cycle with valid high and no ready
   modport sink (
      input  valid, index, top, center, bottom
   );

endinterface

`default_nettype wire

//--- logic/thinning_cell.sv
`timescale 1ns/1ps
`default_nettype none

module thinning_cell import thin_pkg::*; (
   input  cell_slice_t top,
   input  cell_slice_t center,
   input  cell_slice_t bottom,
   output logic        result
);

   // Neighbour ring N NE E SE S SW W NW in bits 7 down to 0
   logic [7:0] nbr;
   logic [3:0] b_count;
   logic [3:0] a_count;
   logic       remove;

   assign nbr = {top[1], top[0], center[0], bottom[0],
                 bottom[1], bottom[2], center[2], top[2]};

   always_comb begin
      b_count = '0;
      a_count = '0;
      for (int k = 0; k < 8; k++) begin
         b_count = b_count + 4'(nbr[k]);
         // Step from nbr[k+1] to nbr[k] with NW wrapping back to N
         if (!nbr[(k + 1) % 8] && nbr[k])
            a_count = a_count + 4'd1;
      end
      remove = center[1] && (b_count >= 4'd2) && (b_count <= 4'd6) && (a_count == 4'd1)
               && !(nbr[7] && nbr[5] && nbr[3])
               && !(nbr[5] && nbr[3] && nbr[1]);
      result = center[1] && !remove;
   end

endmodule

`default_nettype wire

//--- logic/thinning_row.sv
`timescale 1ns/1ps
`default_nettype none

module thinning_row import thin_pkg::*; (
   input  logic clk,
   input  logic reset,
   row_if.sink   window_bus,
   row_if.source result_bus
);

   row_t next_row;

   // Edge columns have no full neighbourhood and pass through
   assign next_row[ROW_WIDTH-1] = window_bus.center[ROW_WIDTH-1];
   assign next_row[0]           = window_bus.center[0];

   for (genvar col = ROW_WIDTH - 2; col >= 1; col = col - 1) begin : g_cell
      thinning_cell u_cell (
         .top    (window_bus.top[col+1 -: 3]),
         .center (window_bus.center[col+1 -: 3]),
         .bottom (window_bus.bottom[col+1 -: 3]),
         .result (next_row[col])
      );
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         result_bus.valid <= 1'b0;
      end else begin
         result_bus.valid <= window_bus.valid;
      end
   end

   always_ff @(posedge clk) begin
      result_bus.index  <= window_bus.index;
      result_bus.center <= next_row;
   end

   assign result_bus.top    = '0;
   assign result_bus.bottom = '0;

endmodule

`default_nettype wire

//--- logic/window_feeder.sv
`timescale 1ns/1ps
`default_nettype none

module window_feeder import thin_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       in_we,
   input  row_index_t in_addr,
   input  row_t       in_data,
   input  logic       start,
   input  row_index_t rd_index,
   output row_t       rd_in_row,
   output logic       busy,
   row_if.source      window_bus
);

   typedef enum logic {
      s_idle,
      s_scan
   } feed_state_t;

   feed_state_t state;
   scan_count_t count;
   row_index_t  row;
   row_t        mem [ROW_COUNT];

   assign busy = (state == s_scan);
   assign row  = row_index_t'(count);

   // Image is frozen during a pass
   always_ff @(posedge clk) begin
      if (in_we && !busy)
         mem[in_addr] <= in_data;
   end

   assign rd_in_row = mem[rd_index];

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= s_idle;
         count <= '0;
      end else begin
         case (state)
            s_idle: begin
               if (start) begin
                  state <= s_scan;
                  count <= '0;
               end
            end
            s_scan: begin
               // Last two counts only drain the pipeline
               if (count == scan_count_t'(SCAN_LAST))
                  state <= s_idle;
               count <= count + scan_count_t'(1);
            end
            default: state <= s_idle;
         endcase
      end
   end

   assign window_bus.valid  = busy && (count < scan_count_t'(ROW_COUNT));
   assign window_bus.index  = row;
   assign window_bus.center = mem[row];
   // Rows outside the image read as zero
   assign window_bus.top    = (row != '0) ? mem[row - row_index_t'(1)] : '0;
   assign window_bus.bottom = (row != row_index_t'(ROW_COUNT - 1)) ?
                              mem[row + row_index_t'(1)] : '0;

endmodule

`default_nettype wire

//--- logic/result_collector.sv
`timescale 1ns/1ps
`default_nettype none

module result_collector import thin_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       start,
   row_if.sink        result_bus,
   input  row_index_t rd_index,
   output row_t       rd_out_row,
   output logic       done
);

   logic       wr_valid;
   row_index_t wr_index;
   row_t       wr_row;
   row_t       mem [ROW_COUNT];

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_valid <= 1'b0;
      end else begin
         wr_valid <= result_bus.valid;
      end
   end

   always_ff @(posedge clk) begin
      wr_index <= result_bus.index;
      wr_row   <= result_bus.center;
      if (wr_valid)
         mem[wr_index] <= wr_row;
   end

   assign rd_out_row = mem[rd_index];

   // Completion wins over a start that the feeder refused while busy
   always_ff @(posedge clk) begin
      if (reset) begin
         done <= 1'b0;
      end else if (wr_valid && wr_index == row_index_t'(ROW_COUNT - 1)) begin
         done <= 1'b1;
      end else if (start) begin
         done <= 1'b0;
      end
   end

endmodule

`default_nettype wire

//--- logic/wb_thin_regs.sv
`timescale 1ns/1ps
`default_nettype none

module wb_thin_regs import thin_pkg::*, bus_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       wb_cyc,
   input  logic       wb_stb,
   input  logic       wb_we,
   input  wb_addr_t   wb_adr,
   input  wb_data_t   wb_dat_w,
   output wb_data_t   wb_dat_r,
   output logic       wb_ack,
   output logic       in_we,
   output logic       start,
   output row_index_t in_addr,
   output row_index_t rd_index,
   output row_t       in_data,
   input  row_t       rd_in_row,
   input  row_t       rd_out_row,
   input  logic       busy,
   input  logic       done
);

   logic     req;
   logic     in_hit;
   logic     out_hit;
   wb_data_t rd_word;

   // New request only when no ack is outstanding
   assign req     = wb_cyc && wb_stb && !wb_ack;
   assign in_hit  = (wb_adr & ROW_REGION_MASK) == IN_BASE;
   assign out_hit = (wb_adr & ROW_REGION_MASK) == OUT_BASE;

   // Low address bits pick the row in either memory
   assign rd_index = row_index_t'(wb_adr);

   always_comb begin
      rd_word = '0;
      if (in_hit)
         rd_word = wb_data_t'(rd_in_row);
      else if (out_hit)
         rd_word = wb_data_t'(rd_out_row);
      else if (wb_adr == STATUS_ADDR)
         rd_word = wb_data_t'({done, busy});
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wb_ack <= 1'b0;
         in_we  <= 1'b0;
         start  <= 1'b0;
      end else begin
         wb_ack <= req;
         in_we  <= req && wb_we && in_hit;
         start  <= req && wb_we && (wb_adr == CTRL_ADDR) && wb_dat_w[0];
      end
   end

   always_ff @(posedge clk) begin
      if (req) begin
         wb_dat_r <= rd_word;
         in_addr  <= row_index_t'(wb_adr);
         in_data  <= row_t'(wb_dat_w);
      end
   end

endmodule

`default_nettype wire

//--- logic/thinning_top.sv
`timescale 1ns/1ps
`default_nettype none

module thinning_top import thin_pkg::*, bus_pkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  logic     wb_cyc,
   input  logic     wb_stb,
   input  logic     wb_we,
   input  wb_addr_t wb_adr,
   input  wb_data_t wb_dat_w,
   output wb_data_t wb_dat_r,
   output logic     wb_ack
);

   logic       in_we;
   logic       start;
   logic       busy;
   logic       done;
   row_index_t in_addr;
   row_index_t rd_index;
   row_t       in_data;
   row_t       rd_in_row;
   row_t       rd_out_row;

   row_if window_bus ();
   row_if result_bus ();

   wb_thin_regs u_regs (
      .clk        (clk),
      .reset      (reset),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_w   (wb_dat_w),
      .wb_dat_r   (wb_dat_r),
      .wb_ack     (wb_ack),
      .in_we      (in_we),
      .start      (start),
      .in_addr    (in_addr),
      .rd_index   (rd_index),
      .in_data    (in_data),
      .rd_in_row  (rd_in_row),
      .rd_out_row (rd_out_row),
      .busy       (busy),
      .done       (done)
   );

   window_feeder u_feeder (
      .clk        (clk),
      .reset      (reset),
      .in_we      (in_we),
      .in_addr    (in_addr),
      .in_data    (in_data),
      .start      (start),
      .rd_index   (rd_index),
      .rd_in_row  (rd_in_row),
      .busy       (busy),
      .window_bus (window_bus.source)
   );

   thinning_row u_row (
      .clk        (clk),
      .reset      (reset),
      .window_bus (window_bus.sink),
      .result_bus (result_bus.source)
   );

   result_collector u_collector (
      .clk        (clk),
      .reset      (reset),
      .start      (start),
      .result_bus (result_bus.sink),
      .rd_index   (rd_index),
      .rd_out_row (rd_out_row),
      .done       (done)
   );

endmodule

`default_nettype wire

//--- testbench/thinning_tb.sv
`timescale 1ns/1ps
`default_nettype none

module thinning_tb import thin_pkg::*, bus_pkg::*; ();

   localparam int ACK_TIMEOUT   = 20;
   localparam int POLL_TIMEOUT  = 100;
   localparam int DRAIN_TIMEOUT = 100;

   logic     clk;
   logic     reset;
   logic     wb_cyc;
   logic     wb_stb;
   logic     wb_we;
   wb_addr_t wb_adr;
   wb_data_t wb_dat_w;
   wb_data_t wb_dat_r;
   logic     wb_ack;

   integer   seed;
   row_t     img [ROW_COUNT];
   row_t     res [ROW_COUNT];
   wb_data_t rd_word;
   int       test_errs;
   int       pass_count;
   int       fail_count;

   // Pending comparisons that the compare process drains on each rising edge
   logic [31:0] exp_q [$];
   logic [31:0] act_q [$];
   string       tag_q [$];
   logic [31:0] cmp_exp;
   logic [31:0] cmp_act;
   string       cmp_tag;

   thinning_top UUT (
      .clk      (clk),
      .reset    (reset),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack)
   );

   always #2 clk = ~clk;

   always @(posedge clk) begin
      while (exp_q.size() > 0) begin
         cmp_exp = exp_q.pop_front();
         cmp_act = act_q.pop_front();
         cmp_tag = tag_q.pop_front();
         if (cmp_act !== cmp_exp) begin
            $display("Fail %s: expected %h, actual %h", cmp_tag, cmp_exp, cmp_act);
            test_errs++;
         end
      end
   end

   // Pixel outside the image reads as zero
   function automatic int pix(input int r, input int c);
      if (r < 0 || r >= ROW_COUNT)
         return 0;
      return int'(img[r][c]);
   endfunction

   // Zhang-Suen first sub-iteration for one row
   // East of column c is column c-1
   function automatic row_t thin_ref(input int r);
      row_t res_row;
      int   ring [8];
      int   b;
      int   a;
      res_row = img[r];
      for (int c = 1; c <= ROW_WIDTH - 2; c++) begin
         ring[0] = pix(r - 1, c);
         ring[1] = pix(r - 1, c - 1);
         ring[2] = pix(r, c - 1);
         ring[3] = pix(r + 1, c - 1);
         ring[4] = pix(r + 1, c);
         ring[5] = pix(r + 1, c + 1);
         ring[6] = pix(r, c + 1);
         ring[7] = pix(r - 1, c + 1);
         b = 0;
         a = 0;
         for (int k = 0; k < 8; k++) begin
            b = b + ring[k];
            if (ring[k] == 0 && ring[(k + 1) % 8] == 1)
               a = a + 1;
         end
         if (img[r][c] && b >= 2 && b <= 6 && a == 1 &&
             ring[0] * ring[2] * ring[4] == 0 && ring[2] * ring[4] * ring[6] == 0)
            res_row[c] = 1'b0;
      end
      return res_row;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("tests failed");
      $finish;
   endtask

   task automatic bus_access(input wb_addr_t addr, input logic we, input wb_data_t data);
      int n;
      n = 0;
      @(negedge clk);
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = addr;
      wb_dat_w = data;
      do begin
         @(negedge clk);
         n++;
      end while (!wb_ack && n < ACK_TIMEOUT);
      if (!wb_ack)
         abort_run($sformatf("no bus ack for address %h", addr));
      rd_word = wb_dat_r;
      wb_cyc  = 1'b0;
      wb_stb  = 1'b0;
      wb_we   = 1'b0;
   endtask

   task automatic wb_write(input wb_addr_t addr, input wb_data_t data);
      bus_access(addr, 1'b1, data);
   endtask

   task automatic wb_read(input wb_addr_t addr, output wb_data_t data);
      bus_access(addr, 1'b0, '0);
      data = rd_word;
   endtask

   task automatic expect_word(input string tag, input logic [31:0] exp, input logic [31:0] act);
      exp_q.push_back(exp);
      act_q.push_back(act);
      tag_q.push_back(tag);
   endtask

   task automatic close_test(input string name);
      int n;
      n = 0;
      while (exp_q.size() > 0 && n < DRAIN_TIMEOUT) begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() > 0)
         abort_run("compare queue did not drain");
      if (test_errs == 0) begin
         $display("%s: passed", name);
         pass_count++;
      end else begin
         $display("%s: %0d mismatches", name, test_errs);
         fail_count++;
      end
      test_errs = 0;
   endtask

   task automatic fill_random();
      for (int r = 0; r < ROW_COUNT; r++)
         img[r] = $random(seed);
   endtask

   task automatic load_image();
      for (int r = 0; r < ROW_COUNT; r++)
         wb_write(wb_addr_t'(IN_BASE + r), img[r]);
   endtask

   task automatic wait_done();
      wb_data_t st;
      int       n;
      n = 0;
      st = '0;
      while (!st[1] && n < POLL_TIMEOUT) begin
         wb_read(STATUS_ADDR, st);
         n++;
      end
      if (!st[1])
         abort_run("done never set after start");
   endtask

   task automatic run_pass();
      wb_write(CTRL_ADDR, 32'h1);
      wait_done();
   endtask

   // Reads the output image and checks every row against the reference
   task automatic check_result(input string name);
      for (int r = 0; r < ROW_COUNT; r++) begin
         wb_read(wb_addr_t'(OUT_BASE + r), res[r]);
         expect_word($sformatf("%s row %0d", name, r), thin_ref(r), res[r]);
      end
   endtask

   initial begin
      clk        = 1'b0;
      reset      = 1'b1;
      wb_cyc     = 1'b0;
      wb_stb     = 1'b0;
      wb_we      = 1'b0;
      wb_adr     = '0;
      wb_dat_w   = '0;
      seed       = 32'hc242_9106;
      test_errs  = 0;
      pass_count = 0;
      fail_count = 0;
      repeat (10) @(negedge clk);
      reset = 1'b0;

      wb_read(STATUS_ADDR, rd_word);
      expect_word("reset_status", 32'h0, rd_word);
      close_test("reset_status");

      fill_random();
      load_image();
      for (int r = 0; r < ROW_COUNT; r++) begin
         wb_read(wb_addr_t'(IN_BASE + r), rd_word);
         expect_word($sformatf("input_readback row %0d", r), img[r], rd_word);
      end
      close_test("input_readback");

      run_pass();
      check_result("random_image");
      wb_read(STATUS_ADDR, rd_word);
      expect_word("random_image status", 32'h2, rd_word);
      close_test("random_image");

      // Block in rows 4 to 9, diagonal, isolated pixel and edge columns
      // Edge pairs would be thinned away if the edge columns were not copied
      for (int r = 0; r < ROW_COUNT; r++)
         img[r] = '0;
      for (int r = 4; r <= 9; r++)
         img[r] = 32'h001F_F000;
      for (int r = 14; r <= 22; r++)
         img[r] = 32'h1 << (39 - r);
      img[26] = 32'h0000_0400;
      for (int r = 0; r <= 2; r++)
         img[r] = 32'hC000_0003;
      for (int r = 28; r <= 31; r++)
         img[r] = 32'hC000_0003;
      load_image();
      run_pass();
      check_result("shapes");
      expect_word("shapes block corner", 32'h0, {31'b0, res[4][20]});
      for (int r = 14; r <= 22; r++)
         expect_word($sformatf("shapes diagonal row %0d", r), img[r], res[r]);
      expect_word("shapes isolated pixel", img[26], res[26]);
      for (int r = 0; r < ROW_COUNT; r++)
         expect_word($sformatf("shapes edge row %0d", r),
                     {30'b0, img[r][31], img[r][0]}, {30'b0, res[r][31], res[r][0]});
      close_test("shapes");

      fill_random();
      img[0]  = '1;
      img[31] = '1;
      load_image();
      run_pass();
      check_result("border_rows");
      close_test("border_rows");

      // Write and second start land while the pass is running
      fill_random();
      load_image();
      wb_write(CTRL_ADDR, 32'h1);
      wb_write(wb_addr_t'(IN_BASE + 5), ~img[5]);
      wb_write(CTRL_ADDR, 32'h1);
      wb_read(STATUS_ADDR, rd_word);
      expect_word("busy_guard status while busy", 32'h1, rd_word);
      wait_done();
      check_result("busy_guard first");
      wb_read(wb_addr_t'(IN_BASE + 5), rd_word);
      expect_word("busy_guard held row 5", img[5], rd_word);
      fill_random();
      load_image();
      run_pass();
      check_result("busy_guard second");
      wb_read(STATUS_ADDR, rd_word);
      expect_word("busy_guard final status", 32'h2, rd_word);
      close_test("busy_guard");

      $display("counts: %0d passed, %0d failed", pass_count, fail_count);
      if (fail_count == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
logic/thin_pkg.sv
logic/bus_pkg.sv
logic/row_if.sv
logic/thinning_cell.sv
logic/thinning_row.sv
logic/window_feeder.sv
logic/result_collector.sv
logic/wb_thin_regs.sv
logic/thinning_top.sv
testbench/thinning_tb.sv

//--- Bender.yml
package:
  name: thinning

sources:
  - logic/thin_pkg.sv
  - logic/bus_pkg.sv
  - logic/row_if.sv
  - logic/thinning_cell.sv
  - logic/thinning_row.sv
  - logic/window_feeder.sv
  - logic/result_collector.sv
  - logic/wb_thin_regs.sv
  - logic/thinning_top.sv
  - target: test
    files:
      - testbench/thinning_tb.sv
